/* include/core_settings.svh */
/*
 * Build-wide sizes for the integer pipeline.
 * Included by the package, the stages that size buffers, and the testbench.
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path width
`define CORE_XLEN 32

// architectural register count, x0 included
`define CORE_NUM_REGS 32

// incoming instruction queue depth, also the sender's starting credits
`define CORE_IN_CREDITS 4

// receiver buffer size seen from core_result
`define CORE_OUT_CREDITS 4

// writeback queue depth
`define CORE_OUT_DEPTH 4

`endif

/* hdl/core_pkg.sv */
/*
 * Types shared by the pipeline stages.
 * Stages import it whole; the structs only live inside queues.
 */
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    // one data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // register file index
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

    // alu operations, the ten rv32i integer ones
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // first operand: register, pc for auipc, zero for lui
    typedef enum logic [1:0] {
        OP1_SRC_RS1,
        OP1_SRC_PC,
        OP1_SRC_ZERO
    } op1_src_e;

    // second operand: register or immediate
    typedef enum logic {
        OP2_SRC_RS2,
        OP2_SRC_IMM
    } op2_src_e;

    // writeback record sent to the receiver
    typedef struct packed {
        reg_idx_t idx;
        word_t    data;
    } wb_entry_t;

endpackage

`default_nettype wire

/* hdl/credit_fifo.sv */
/*
 * Circular queue with a type parameter for its payload.
 * Head entry is visible on o_pop_data whenever the queue is not empty.
 */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_push,
    input  T     i_push_data,
    input  logic i_pop,
    output T     o_pop_data,
    output logic o_empty,
    output logic o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage has no reset, only pointers and count do
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign o_pop_data = mem[rd_ptr];
    assign o_empty    = (count == '0);
    assign o_full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // wrap by compare, depth need not be a power of two
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (i_push && !i_pop) begin
                count <= count + 1'b1;
            end else if (!i_push && i_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/core_alu.sv */
/*
 * Combinational ALU for the RV32I integer operations.
 * Used by the execute stage.
 */
`timescale 1ns/1ps
`default_nettype none

module core_alu
    import core_pkg::*;
(
    input  word_t   i_operand_a,
    input  word_t   i_operand_b,
    input  alu_op_e i_op,
    output word_t   o_result
);

    logic [4:0] shamt;

    // shift amount is the low five bits of b
    assign shamt = i_operand_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_operand_a + i_operand_b;
            ALU_SUB:  o_result = i_operand_a - i_operand_b;
            ALU_SLL:  o_result = i_operand_a << shamt;
            // set-less-than gives 0 or 1
            ALU_SLT:  o_result = word_t'($signed(i_operand_a) < $signed(i_operand_b));
            ALU_SLTU: o_result = word_t'(i_operand_a < i_operand_b);
            ALU_XOR:  o_result = i_operand_a ^ i_operand_b;
            ALU_SRL:  o_result = i_operand_a >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_operand_a) >>> shamt);
            ALU_OR:   o_result = i_operand_a | i_operand_b;
            ALU_AND:  o_result = i_operand_a & i_operand_b;
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/core_decode.sv */
/*
 * Decode stage: pops instruction words, owns the pc, decodes OP, OP-IMM,
 * LUI and AUIPC, reads the register file and registers it all for execute.
 */
`timescale 1ns/1ps
`default_nettype none

module core_decode
    import core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_stall,
    input  word_t    i_instr,
    input  logic     i_instr_empty,
    output logic     o_instr_pop,
    output reg_idx_t o_rs1_idx,
    output reg_idx_t o_rs2_idx,
    input  word_t    i_rs1_data,
    input  word_t    i_rs2_data,
    output logic     o_valid,
    output alu_op_e  o_alu_op,
    output op1_src_e o_op1_src,
    output op2_src_e o_op2_src,
    output reg_idx_t o_rs1_idx_q,
    output reg_idx_t o_rs2_idx_q,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data,
    output word_t    o_imm,
    output word_t    o_pc,
    output reg_idx_t o_rd_idx,
    output logic     o_rd_we
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       op_legal;
    logic       op_imm_legal;
    alu_op_e    f3_op;
    alu_op_e    alu_op;
    op1_src_e   op1_src;
    op2_src_e   op2_src;
    word_t      imm;
    reg_idx_t   rd_idx;
    logic       rd_we;
    word_t      pc;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign alt    = (funct7 == 7'b0100000);

    // take the head word whenever the pipe can move
    assign o_instr_pop = !i_instr_empty && !i_stall;

    // register file read indices straight from the word
    assign o_rs1_idx = i_instr[19:15];
    assign o_rs2_idx = i_instr[24:20];

    // sub and sra are the only funct7 variants
    assign op_legal = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    // immediate shifts keep funct7 in the top imm bits
    always_comb begin
        case (funct3)
            3'b001:  op_imm_legal = (funct7 == 7'b0);
            3'b101:  op_imm_legal = (funct7 == 7'b0) || alt;
            default: op_imm_legal = 1'b1;
        endcase
    end

    always_comb begin
        case (funct3)
            // addi never turns into sub
            3'b000:  f3_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        // unsupported words become add zero, no write, rd x0
        alu_op  = ALU_ADD;
        op1_src = OP1_SRC_ZERO;
        op2_src = OP2_SRC_IMM;
        imm     = '0;
        rd_idx  = '0;
        rd_we   = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (op_legal) begin
                    alu_op  = f3_op;
                    op1_src = OP1_SRC_RS1;
                    op2_src = OP2_SRC_RS2;
                    rd_idx  = i_instr[11:7];
                    rd_we   = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (op_imm_legal) begin
                    alu_op  = f3_op;
                    op1_src = OP1_SRC_RS1;
                    imm     = {{20{i_instr[31]}}, i_instr[31:20]};
                    rd_idx  = i_instr[11:7];
                    rd_we   = 1'b1;
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                // zero plus upper imm, or pc plus upper imm
                op1_src = (opcode == OPC_LUI) ? OP1_SRC_ZERO : OP1_SRC_PC;
                imm     = {i_instr[31:12], 12'b0};
                rd_idx  = i_instr[11:7];
                rd_we   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            pc      <= '0;
        end else if (!i_stall) begin
            o_valid <= o_instr_pop;
            if (o_instr_pop) begin
                pc <= pc + word_t'(4);
            end
        end
    end

    // payload follows valid, held through a stall
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_alu_op    <= alu_op;
            o_op1_src   <= op1_src;
            o_op2_src   <= op2_src;
            o_rs1_idx_q <= o_rs1_idx;
            o_rs2_idx_q <= o_rs2_idx;
            o_rs1_data  <= i_rs1_data;
            o_rs2_data  <= i_rs2_data;
            o_imm       <= imm;
            o_pc        <= pc;
            o_rd_idx    <= rd_idx;
            o_rd_we     <= rd_we;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_execute.sv */
/*
 * Execute stage: forwards the previous result, muxes the ALU operands
 * and registers the result with its destination for the result stage.
 */
`timescale 1ns/1ps
`default_nettype none

module core_execute
    import core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_stall,
    input  logic     i_valid,
    input  alu_op_e  i_alu_op,
    input  op1_src_e i_op1_src,
    input  op2_src_e i_op2_src,
    input  reg_idx_t i_rs1_idx,
    input  reg_idx_t i_rs2_idx,
    input  word_t    i_rs1_data,
    input  word_t    i_rs2_data,
    input  word_t    i_imm,
    input  word_t    i_pc,
    input  reg_idx_t i_rd_idx,
    input  logic     i_rd_we,
    output logic     o_valid,
    output reg_idx_t o_rd_idx,
    output logic     o_rd_we,
    output word_t    o_result
);

    logic  fwd_ok;
    word_t rs1;
    word_t rs2;
    word_t operand_a;
    word_t operand_b;
    word_t alu_result;

    // our own output reg holds the instruction just ahead
    assign fwd_ok = o_valid && o_rd_we && (o_rd_idx != '0);
    assign rs1    = (fwd_ok && o_rd_idx == i_rs1_idx) ? o_result : i_rs1_data;
    assign rs2    = (fwd_ok && o_rd_idx == i_rs2_idx) ? o_result : i_rs2_data;

    always_comb begin
        case (i_op1_src)
            OP1_SRC_RS1: operand_a = rs1;
            OP1_SRC_PC:  operand_a = i_pc;
            default:     operand_a = '0;
        endcase
    end

    assign operand_b = (i_op2_src == OP2_SRC_IMM) ? i_imm : rs2;

    core_alu u_alu (
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_op        (i_alu_op),
        .o_result    (alu_result)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_rd_idx <= i_rd_idx;
            o_rd_we  <= i_rd_we;
            o_result <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_result.sv */
/*
 * Result stage: register file with write-through reads, writeback queue
 * and the credit counter toward the outside receiver.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_result
    import core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    input  reg_idx_t i_rd_idx,
    input  logic     i_rd_we,
    input  word_t    i_result,
    input  reg_idx_t i_rs1_idx,
    input  reg_idx_t i_rs2_idx,
    input  logic     i_wb_credit,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data,
    output logic     o_stage_ready,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_idx,
    output word_t    o_wb_data
);

    localparam int CREDIT_W = $clog2(`CORE_OUT_CREDITS + 1);

    word_t                regs [`CORE_NUM_REGS];
    logic                 retire;
    logic                 rf_we;
    wb_entry_t            wb_push;
    wb_entry_t            wb_head;
    logic                 wb_empty;
    logic                 wb_full;
    logic [CREDIT_W-1:0]  credits;

    // one stall for the whole pipe, raised by a full queue
    assign o_stage_ready = !wb_full;
    assign retire        = i_valid && o_stage_ready;
    assign rf_we         = retire && i_rd_we && (i_rd_idx != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[i_rd_idx] <= i_result;
        end
    end

    // x0 reads zero, a same-cycle write reads through
    assign o_rs1_data = (i_rs1_idx == '0) ? '0 :
                        (rf_we && i_rd_idx == i_rs1_idx) ? i_result : regs[i_rs1_idx];
    assign o_rs2_data = (i_rs2_idx == '0) ? '0 :
                        (rf_we && i_rd_idx == i_rs2_idx) ? i_result : regs[i_rs2_idx];

    // record carries zero data when nothing was written
    always_comb begin
        wb_push.idx  = i_rd_idx;
        wb_push.data = rf_we ? i_result : '0;
    end

    credit_fifo #(
        .T     (wb_entry_t),
        .DEPTH (`CORE_OUT_DEPTH)
    ) u_wb_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (retire),
        .i_push_data (wb_push),
        .i_pop       (o_wb_valid),
        .o_pop_data  (wb_head),
        .o_empty     (wb_empty),
        .o_full      (wb_full)
    );

    // send only with a record ready and a credit in hand
    assign o_wb_valid = !wb_empty && (credits != '0);
    assign o_wb_idx   = wb_head.idx;
    assign o_wb_data  = wb_head.data;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            credits <= CREDIT_W'(`CORE_OUT_CREDITS);
        end else if (o_wb_valid && !i_wb_credit) begin
            credits <= credits - 1'b1;
        end else if (!o_wb_valid && i_wb_credit) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
/*
 * Pipeline top: incoming instruction queue, decode, execute and result,
 * plus the credit pulse back to the instruction sender.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top
    import core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_instr_valid,
    input  word_t    i_instr,
    input  logic     i_wb_credit,
    output logic     o_instr_credit,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_idx,
    output word_t    o_wb_data
);

    // incoming queue
    word_t    in_head;
    logic     in_empty;
    logic     in_full;
    logic     instr_pop;
    // stall
    logic     stage_ready;
    logic     stall;
    // register file read port
    reg_idx_t rf_rs1_idx;
    reg_idx_t rf_rs2_idx;
    word_t    rf_rs1_data;
    word_t    rf_rs2_data;
    // decode to execute
    logic     dec_valid;
    alu_op_e  dec_alu_op;
    op1_src_e dec_op1_src;
    op2_src_e dec_op2_src;
    reg_idx_t dec_rs1_idx;
    reg_idx_t dec_rs2_idx;
    word_t    dec_rs1_data;
    word_t    dec_rs2_data;
    word_t    dec_imm;
    word_t    dec_pc;
    reg_idx_t dec_rd_idx;
    logic     dec_rd_we;
    // execute to result
    logic     exe_valid;
    reg_idx_t exe_rd_idx;
    logic     exe_rd_we;
    word_t    exe_result;

    assign stall = !stage_ready;

    // sender spends a credit per word, so the queue cannot overflow
    credit_fifo #(
        .T     (word_t),
        .DEPTH (`CORE_IN_CREDITS)
    ) u_in_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (i_instr_valid),
        .i_push_data (i_instr),
        .i_pop       (instr_pop),
        .o_pop_data  (in_head),
        .o_empty     (in_empty),
        .o_full      (in_full)
    );

    // one credit back the cycle after each pop
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_instr_credit <= 1'b0;
        end else begin
            o_instr_credit <= instr_pop;
        end
    end

    core_decode u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (stall),
        .i_instr       (in_head),
        .i_instr_empty (in_empty),
        .o_instr_pop   (instr_pop),
        .o_rs1_idx     (rf_rs1_idx),
        .o_rs2_idx     (rf_rs2_idx),
        .i_rs1_data    (rf_rs1_data),
        .i_rs2_data    (rf_rs2_data),
        .o_valid       (dec_valid),
        .o_alu_op      (dec_alu_op),
        .o_op1_src     (dec_op1_src),
        .o_op2_src     (dec_op2_src),
        .o_rs1_idx_q   (dec_rs1_idx),
        .o_rs2_idx_q   (dec_rs2_idx),
        .o_rs1_data    (dec_rs1_data),
        .o_rs2_data    (dec_rs2_data),
        .o_imm         (dec_imm),
        .o_pc          (dec_pc),
        .o_rd_idx      (dec_rd_idx),
        .o_rd_we       (dec_rd_we)
    );

    core_execute u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (stall),
        .i_valid    (dec_valid),
        .i_alu_op   (dec_alu_op),
        .i_op1_src  (dec_op1_src),
        .i_op2_src  (dec_op2_src),
        .i_rs1_idx  (dec_rs1_idx),
        .i_rs2_idx  (dec_rs2_idx),
        .i_rs1_data (dec_rs1_data),
        .i_rs2_data (dec_rs2_data),
        .i_imm      (dec_imm),
        .i_pc       (dec_pc),
        .i_rd_idx   (dec_rd_idx),
        .i_rd_we    (dec_rd_we),
        .o_valid    (exe_valid),
        .o_rd_idx   (exe_rd_idx),
        .o_rd_we    (exe_rd_we),
        .o_result   (exe_result)
    );

    core_result u_result (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (exe_valid),
        .i_rd_idx      (exe_rd_idx),
        .i_rd_we       (exe_rd_we),
        .i_result      (exe_result),
        .i_rs1_idx     (rf_rs1_idx),
        .i_rs2_idx     (rf_rs2_idx),
        .i_wb_credit   (i_wb_credit),
        .o_rs1_data    (rf_rs1_data),
        .o_rs2_data    (rf_rs2_data),
        .o_stage_ready (stage_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb_idx      (o_wb_idx),
        .o_wb_data     (o_wb_data)
    );

endmodule

`default_nettype wire

/* testbench/core_top_properties.sv */
/*
 * Concurrent checks on the pipeline top, attached by bind.
 * Covers queue overflow, outgoing credits and decode hold during a stall.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top_properties (
    input wire logic        i_clk,
    input wire logic        i_rst_n,
    input wire logic        i_push,
    input wire logic        i_full,
    input wire logic        i_stall,
    input wire logic        i_dec_valid,
    input wire logic [4:0]  i_dec_rd_idx,
    input wire logic        i_dec_rd_we,
    input wire logic [31:0] i_dec_imm,
    input wire logic [31:0] i_dec_pc,
    input wire logic        i_wb_valid,
    input wire logic        i_wb_credit,
    input wire logic [$clog2(`CORE_OUT_CREDITS + 1)-1:0] i_credits
);

    // receiver credits counted from the port traffic alone
    int port_credits;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            port_credits <= `CORE_OUT_CREDITS;
        end else begin
            port_credits <= port_credits - int'(i_wb_valid) + int'(i_wb_credit);
        end
    end

    // sender credits keep the input queue from overflowing
    assert property (@(posedge i_clk) disable iff (!i_rst_n) !(i_push && i_full))
        else $error("push into a full input queue");

    // never send without a credit
    assert property (@(posedge i_clk) disable iff (!i_rst_n) !(i_wb_valid && port_credits <= 0))
        else $error("writeback sent with zero credits");

    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_credits <= `CORE_OUT_CREDITS)
        else $error("outgoing credit count above its start value");

    // a stalled decode register holds its instruction
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stall && i_dec_valid) |=> (i_dec_valid && $stable(i_dec_rd_idx)
            && $stable(i_dec_rd_we) && $stable(i_dec_imm) && $stable(i_dec_pc)))
        else $error("decode output changed during a stall");

endmodule

bind core_top core_top_properties u_props (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_push       (i_instr_valid),
    .i_full       (in_full),
    .i_stall      (stall),
    .i_dec_valid  (dec_valid),
    .i_dec_rd_idx (dec_rd_idx),
    .i_dec_rd_we  (dec_rd_we),
    .i_dec_imm    (dec_imm),
    .i_dec_pc     (dec_pc),
    .i_wb_valid   (o_wb_valid),
    .i_wb_credit  (i_wb_credit),
    .i_credits    (u_result.credits)
);

`default_nettype wire

/* testbench/tb_core_top.sv */
/*
 * Testbench for core_top: seeded random instructions under credits,
 * a register model that predicts each writeback record, and a timeout.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_core_top;

    localparam int N_ALU   = 40;
    localparam int N_BYP   = 24;
    localparam int N_UPPER = 16;
    localparam int N_X0    = 12;
    localparam int N_SLOW  = 30;
    localparam int N_BAD   = 16;
    localparam int TOTAL   = N_ALU + N_BYP + N_UPPER + N_X0 + N_SLOW + N_BAD;
    // 20 cycles per instruction over all tests
    localparam int LIMIT   = 20 * TOTAL;

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic        i_instr_valid;
    logic [31:0] i_instr;
    logic        i_wb_credit = 1'b0;
    logic        o_instr_credit;
    logic        o_wb_valid;
    logic [4:0]  o_wb_idx;
    logic [31:0] o_wb_data;

    integer seed        = 32'hd975_bdc4;
    integer credit_seed = 32'hd975_bdc4;
    int     errors      = 0;
    int     checks      = 0;
    int     cycles      = 0;
    int     in_credits  = `CORE_IN_CREDITS;
    int     outstanding = 0;
    int     credit_pct  = 50;
    // model state
    logic [31:0] mregs [32];
    logic [31:0] model_pc;
    // expected records in program order, {idx, data}
    logic [36:0] exp_mem [TOTAL];
    int          exp_wr = 0;
    int          exp_rd = 0;

    core_top i_core_top (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_wb_credit    (i_wb_credit),
        .o_instr_credit (o_instr_credit),
        .o_wb_valid     (o_wb_valid),
        .o_wb_idx       (o_wb_idx),
        .o_wb_data      (o_wb_data)
    );

    always #20 i_clk = ~i_clk;

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // rv32i integer semantics by funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        legal;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        rd    = w[11:7];
        a     = mregs[w[19:15]];
        b     = mregs[w[24:20]];
        legal = 1'b0;
        res   = '0;
        case (opc)
            7'h33: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                res   = alu_ref(f3, f7 == 7'h20, a, b);
            end
            7'h13: begin
                b     = {{20{w[31]}}, w[31:20]};
                legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                        (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                res   = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, b);
            end
            7'h37: begin
                legal = 1'b1;
                res   = {w[31:12], 12'b0};
            end
            7'h17: begin
                legal = 1'b1;
                res   = model_pc + {w[31:12], 12'b0};
            end
            default: ;
        endcase
        // x0 and unsupported words give index or data zero
        if (!legal) begin
            rd = '0;
        end
        if (legal && rd != '0) begin
            mregs[rd] = res;
        end else begin
            res = '0;
        end
        exp_mem[exp_wr] = {rd, res};
        exp_wr++;
        model_pc = model_pc + 32'd4;
    endtask

    // random OP or OP-IMM word, legal encodings only
    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3  = 3'(rnd(8));
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00;
        imm = 12'(rnd(4096));
        if (rnd(2) == 0) begin
            return {f7, rs2, rs1, f3, rd, 7'h33};
        end
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm[11:5] = f7;
        end
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    // called on a falling edge, waits for a credit
    task automatic send_instr(input logic [31:0] w);
        while (in_credits == 0) begin
            @(negedge i_clk);
        end
        model_step(w);
        i_instr_valid = 1'b1;
        i_instr       = w;
        @(negedge i_clk);
        i_instr_valid = 1'b0;
    endtask

    // drain all records and sender credits, then report
    task automatic finish_test(input string name, input int err_before);
        while (exp_rd != exp_wr || in_credits != `CORE_IN_CREDITS) begin
            @(negedge i_clk);
        end
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    always @(negedge i_clk) begin
        int r;
        r = $random(credit_seed);
        i_wb_credit = i_rst_n && outstanding > 0 && ((r & 32'h7fff_ffff) % 100) < credit_pct;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end else if (!i_rst_n) begin
            in_credits  = `CORE_IN_CREDITS;
            outstanding = 0;
        end else begin
            in_credits  = in_credits + int'(o_instr_credit) - int'(i_instr_valid);
            outstanding = outstanding + int'(o_wb_valid) - int'(i_wb_credit);
            if (outstanding > `CORE_OUT_CREDITS) begin
                errors++;
                $display("Receiver buffer overrun with %0d records outstanding", outstanding);
            end
            if (o_wb_valid) begin
                if (exp_rd == exp_wr) begin
                    errors++;
                    $display("Writeback record arrived with no instruction pending");
                end else begin
                    checks++;
                    if (o_wb_idx !== exp_mem[exp_rd][36:32]) begin
                        errors++;
                        $display("Error: o_wb_idx got %h expected %h", o_wb_idx,
                                 exp_mem[exp_rd][36:32]);
                    end
                    if (o_wb_data !== exp_mem[exp_rd][31:0]) begin
                        errors++;
                        $display("Error: o_wb_data got %h expected %h", o_wb_data,
                                 exp_mem[exp_rd][31:0]);
                    end
                    exp_rd++;
                end
            end
        end
    end

    initial begin
        int         e0;
        logic [4:0] prev;
        logic [4:0] rd;
        logic [6:0] bad_opc [7];
        logic [31:0] w;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        model_pc      = '0;
        bad_opc       = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h73, 7'h0f};
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // random alu mix, lui seeds the registers
        e0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            rd = 5'(rnd(31) + 1);
            if (rnd(4) == 0) begin
                send_instr({20'(rnd(1 << 20)), rd, 7'h37});
            end else begin
                send_instr(rand_alu(rd, 5'(rnd(32)), 5'(rnd(32))));
            end
        end
        finish_test("alu_random", e0);

        // each instruction reads the one just ahead
        e0   = errors;
        prev = 5'd5;
        for (int i = 0; i < N_BYP; i++) begin
            rd = 5'(rnd(31) + 1);
            send_instr(rand_alu(rd, prev, prev));
            prev = rd;
        end
        finish_test("bypass_chain", e0);

        e0 = errors;
        for (int i = 0; i < N_UPPER; i++) begin
            rd = 5'(rnd(31) + 1);
            send_instr({20'(rnd(1 << 20)), rd, (i % 2 == 0) ? 7'h17 : 7'h37});
        end
        finish_test("lui_auipc", e0);

        // writes to x0, then reads of x0
        e0 = errors;
        for (int i = 0; i < N_X0; i++) begin
            if (i < N_X0 / 2) begin
                send_instr(rand_alu(5'd0, 5'(rnd(32)), 5'(rnd(32))));
            end else begin
                send_instr(rand_alu(5'(rnd(31) + 1), 5'd0, 5'd0));
            end
        end
        finish_test("x0_writes", e0);

        // rare credit returns
        e0         = errors;
        credit_pct = 15;
        for (int i = 0; i < N_SLOW; i++) begin
            send_instr(rand_alu(5'(rnd(31) + 1), 5'(rnd(32)), 5'(rnd(32))));
        end
        finish_test("slow_credits", e0);
        credit_pct = 50;

        // unsupported opcodes and funct7, then register reads
        e0 = errors;
        for (int i = 0; i < N_BAD; i++) begin
            w = $random(seed);
            if (i >= N_BAD - 4) begin
                w = rand_alu(5'(rnd(31) + 1), 5'(rnd(32)), 5'(rnd(32)));
            end else if (i % 3 == 0) begin
                w[31:25] = 7'h01;
                w[6:0]   = 7'h33;
            end else begin
                w[6:0] = bad_opc[rnd(7)];
            end
            send_instr(w);
        end
        finish_test("unsupported", e0);

        $display("Tests done: %0d records checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
hdl/core_pkg.sv
hdl/credit_fifo.sv
hdl/core_alu.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/core_top.sv
testbench/core_top_properties.sv
testbench/tb_core_top.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_core_top
	out=$$(./obj_dir/Vtb_core_top); echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
